/* sources.f */
design/game_pkg.sv
design/link_if.sv
design/round_if.sv
design/round_judge.sv
design/score_control.sv
design/link_arbiter.sv
design/shootout_top.sv
tb/shootout_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := shootout_tb
FLIST     := sources.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Testbench passed$$'

clean:
	rm -rf $(OBJ_DIR)

/* tb/shootout_tb.sv */
/*
 * Testbench for the penalty shootout scoring subsystem.
 * Plays three matches with LCG directions and checks every link frame
 * and the score ports against a reference model.
 */

module shootout_tb import game_pkg::*; ();

    localparam int SHOTS_MAX  = 40;
    localparam int MAX_CYCLES = SHOTS_MAX * 8 + 200;

    logic        clk;
    logic        rst;
    g_state      game_state;
    logic        shot;
    dir_t        shot_dir;
    dir_t        keeper_dir;
    score_t      score_player;
    score_t      score_enemy;
    logic        match_end;
    logic        match_result;
    logic        frame_valid;
    frame_kind_t frame_kind;
    frame_t      frame_data;

    logic [31:0] seed;
    int          cycles;
    int          frames_seen;
    int          value_errs;
    int          frame_errs;
    frame_t      exp_data[$];      // filled by the stimulus, in link order
    frame_kind_t exp_kind[$];
    score_t      exp_player;
    score_t      exp_enemy;
    logic        exp_end;
    logic        exp_result;

    shootout_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .game_state   (game_state),
        .shot         (shot),
        .shot_dir     (shot_dir),
        .keeper_dir   (keeper_dir),
        .score_player (score_player),
        .score_enemy  (score_enemy),
        .match_end    (match_end),
        .match_result (match_result),
        .frame_valid  (frame_valid),
        .frame_kind   (frame_kind),
        .frame_data   (frame_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, the DUT stopped sending frames", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic dir_t rand_dir();
        logic [7:0] pick;
        seed = lcg_next(seed);
        pick = seed[23:16] % 8'd3;
        case (pick)
            8'd0: return LEFT;
            8'd1: return CENTER;
            default: return RIGHT;
        endcase
    endfunction

    function automatic dir_t other_dir(input dir_t d);
        case (d)
            LEFT: return CENTER;
            CENTER: return RIGHT;
            default: return LEFT;
        endcase
    endfunction

    // role, verdict, shot dir, keeper dir, two zero bits
    function automatic frame_t event_frame(input logic role, input dir_t sdir, input dir_t kdir);
        logic scored;
        scored = (sdir != kdir);    // keeper guessed wrong
        return {role, scored, sdir, kdir, 2'b00};
    endfunction

    function automatic frame_t score_model(input logic role, input logic scored);
        if (scored && role) begin
            exp_player = exp_player + 3'd1;
        end else if (scored) begin
            exp_enemy = exp_enemy + 3'd1;   // goal against the player
        end
        exp_end    = (exp_player == WIN_SCORE) || (exp_enemy == WIN_SCORE);
        exp_result = (exp_player == WIN_SCORE);
        return {exp_end, exp_result, exp_player, exp_enemy};
    endfunction

    task automatic check_frame(input frame_t got, input frame_t exp, input string what);
        if (got !== exp) begin
            value_errs = value_errs + 1;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_score(input score_t got, input score_t exp, input string what);
        if (got !== exp) begin
            value_errs = value_errs + 1;
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errs = value_errs + 1;
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_kind(input frame_kind_t got, input frame_kind_t exp, input string what);
        if (got !== exp) begin
            value_errs = value_errs + 1;
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // frame monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && frame_valid === 1'b1) begin
            frames_seen = frames_seen + 1;
            if (exp_data.size() == 0) begin
                frame_errs = frame_errs + 1;
                $display("unexpected frame %h on the link at time %0t", frame_data, $time);
            end else begin
                check_kind(frame_kind, exp_kind.pop_front(), "frame kind");
                check_frame(frame_data, exp_data.pop_front(), "frame data");
            end
        end
    end

    task automatic check_ports();
        check_score(score_player, exp_player, "score_player");
        check_score(score_enemy, exp_enemy, "score_enemy");
        check_bit(match_end, exp_end, "match_end");
        check_bit(match_result, exp_result, "match_result");
    endtask

    task automatic take_shot(input g_state st, input dir_t sdir, input dir_t kdir,
                             input logic twice);
        logic live;
        logic role;
        int   target;
        live   = !exp_end;          // judge ignores shots once the match is over
        role   = (st == SHOOTER);
        target = frames_seen;
        if (live) begin
            exp_kind.push_back(FRAME_EVENT);
            exp_data.push_back(event_frame(role, sdir, kdir));
            exp_kind.push_back(FRAME_SCORE);
            exp_data.push_back(score_model(role, sdir != kdir));
            target = target + 2;
        end
        @(posedge clk);
        #1;
        game_state = st;
        shot       = 1'b1;
        shot_dir   = sdir;
        keeper_dir = kdir;
        @(posedge clk);
        #1;
        shot = twice;               // repeat lands while the event frame waits
        @(posedge clk);
        #1;
        shot = 1'b0;
        if (live) begin
            while (frames_seen < target) @(posedge clk);
        end else begin
            repeat (6) @(posedge clk);
        end
        #1;
        if (frames_seen != target) begin
            frame_errs = frame_errs + 1;
            $display("shot at time %0t gave %0d frames instead of %0d",
                     $time, frames_seen - target + (live ? 2 : 0), live ? 2 : 0);
        end
        check_ports();
    endtask

    task automatic go_idle();
        @(posedge clk);
        #1;
        game_state = IDLE;
        repeat (2) @(posedge clk);
        #1;
        exp_player = '0;
        exp_enemy  = '0;
        exp_end    = 1'b0;
        exp_result = 1'b0;
        check_ports();
    endtask

    initial begin
        int   i;
        dir_t sd;
        dir_t kd;
        clk         = 1'b0;
        rst         = 1'b1;
        game_state  = IDLE;
        shot        = 1'b0;
        shot_dir    = LEFT;
        keeper_dir  = LEFT;
        seed        = 32'h2f28_ade2;
        cycles      = 0;
        frames_seen = 0;
        value_errs  = 0;
        frame_errs  = 0;
        exp_player  = '0;
        exp_enemy   = '0;
        exp_end     = 1'b0;
        exp_result  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_ports();
        repeat (3) @(posedge clk);
        #1;
        if (frames_seen != 0) begin
            frame_errs = frame_errs + 1;
            $display("frames appeared on the link before the first shot");
        end

        // match 1, roles alternate, random directions
        for (i = 0; i < 20 && !exp_end; i++) begin
            sd = rand_dir();
            kd = rand_dir();
            take_shot((i % 2 == 1) ? SHOOTER : KEEPER, sd, kd, (i % 4 == 2));
        end
        take_shot(SHOOTER, LEFT, RIGHT, 1'b0);
        take_shot(KEEPER, RIGHT, CENTER, 1'b0);
        go_idle();

        // match 2, player scores after one save
        for (i = 0; i < 7 && !exp_end; i++) begin
            sd = rand_dir();
            kd = (i == 0) ? sd : other_dir(sd);
            take_shot(SHOOTER, sd, kd, (i == 2));
        end
        check_bit(match_result, 1'b1, "match_result after player win");
        take_shot(SHOOTER, CENTER, LEFT, 1'b0);
        go_idle();

        // match 3, enemy scores with one save in between
        for (i = 0; i < 6 && !exp_end; i++) begin
            sd = rand_dir();
            kd = (i == 3) ? sd : other_dir(sd);
            take_shot(KEEPER, sd, kd, 1'b0);
        end
        check_bit(match_end, 1'b1, "match_end after enemy win");
        check_bit(match_result, 1'b0, "match_result after enemy win");

        repeat (3) @(posedge clk);
        #1;
        if (exp_data.size() != 0) begin
            frame_errs = frame_errs + exp_data.size();
            $display("%0d expected frames never arrived", exp_data.size());
        end
        $display("errors: %0d wrong values, %0d frame count", value_errs, frame_errs);
        if (value_errs == 0 && frame_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* design/shootout_top.sv */
/*
 * Penalty shootout scoring subsystem.
 * Round judge and score controller share one outgoing byte link
 * to the partner board through a round-robin arbiter.
 */

module shootout_top import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  g_state      game_state,
    input  logic        shot,
    input  dir_t        shot_dir,
    input  dir_t        keeper_dir,
    output score_t      score_player,
    output score_t      score_enemy,
    output logic        match_end,
    output logic        match_result,
    output logic        frame_valid,
    output frame_kind_t frame_kind,
    output frame_t      frame_data
);

    link_if  event_link ();
    link_if  score_link ();
    round_if round_bus ();

    round_judge u_judge (
        .clk        (clk),
        .rst        (rst),
        .game_state (game_state),
        .shot       (shot),
        .shot_dir   (shot_dir),
        .keeper_dir (keeper_dir),
        .round      (round_bus.judge),
        .link       (event_link.peer)
    );

    score_control u_score (
        .clk          (clk),
        .rst          (rst),
        .game_state   (game_state),
        .round        (round_bus.scorer),
        .link         (score_link.peer),
        .score_player (score_player),
        .score_enemy  (score_enemy),
        .match_end    (match_end),
        .match_result (match_result)
    );

    link_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .event_link  (event_link.arbiter),
        .score_link  (score_link.arbiter),
        .frame_valid (frame_valid),
        .frame_kind  (frame_kind),
        .frame_data  (frame_data)
    );

endmodule

/* design/link_arbiter.sv */
/*
 * Link arbiter.
 * Two-way round robin between the event and score peers,
 * the winner's byte is registered as a one-cycle frame strobe.
 */

module link_arbiter import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    link_if.arbiter     event_link,
    link_if.arbiter     score_link,
    output logic        frame_valid,
    output frame_kind_t frame_kind,
    output frame_t      frame_data
);

    logic last_score;   // score peer won last time
    logic event_win;
    logic score_win;

    // on a tie the peer that did not win last goes first
    always_comb begin
        event_win = event_link.req && (!score_link.req || last_score);
        score_win = score_link.req && (!event_link.req || !last_score);
    end

    assign event_link.grant = event_win;
    assign score_link.grant = score_win;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_valid <= 1'b0;
            last_score  <= 1'b0;
        end else begin
            frame_valid <= event_win || score_win;
            if (event_win) begin
                last_score <= 1'b0;
            end else if (score_win) begin
                last_score <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (event_win) begin
            frame_kind <= event_link.kind;
            frame_data <= event_link.data;
        end else if (score_win) begin
            frame_kind <= score_link.kind;
            frame_data <= score_link.data;
        end
    end

    a_one_grant: assert property (
        @(posedge clk) disable iff (rst)
        !(event_link.grant && score_link.grant)
    );

    // a losing peer must keep asking
    a_event_req_held: assert property (
        @(posedge clk) disable iff (rst)
        event_link.req && !event_link.grant |=> event_link.req
    );

endmodule

/* design/score_control.sv */
/*
 * Score controller.
 * Counts goals of both sides from the judge verdicts, ends the match
 * at WIN_SCORE and queues a score frame after every update.
 */

module score_control import game_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  g_state  game_state,
    round_if.scorer round,
    link_if.peer    link,
    output score_t  score_player,
    output score_t  score_enemy,
    output logic    match_end,
    output logic    match_result
);

    typedef enum logic {
        PLAY,
        REPORT      // score frame waiting for grant
    } sc_state_t;

    sc_state_t state;
    score_t    player_nxt;
    score_t    enemy_nxt;
    logic      end_nxt;
    logic      result_nxt;
    logic      update;

    assign update = round.done && (state == PLAY) && (game_state != IDLE);

    always_comb begin
        player_nxt = score_player;
        enemy_nxt  = score_enemy;
        if (round.scored) begin
            if (round.role) begin
                player_nxt = score_player + 3'd1;
            end else begin
                enemy_nxt = score_enemy + 3'd1;     // keeper let one in
            end
        end
        end_nxt    = (player_nxt == WIN_SCORE) || (enemy_nxt == WIN_SCORE);
        result_nxt = (player_nxt == WIN_SCORE);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            score_player <= '0;
            score_enemy  <= '0;
            match_end    <= 1'b0;
            match_result <= 1'b0;
        end else if (game_state == IDLE) begin
            score_player <= '0;     // new match
            score_enemy  <= '0;
            match_end    <= 1'b0;
            match_result <= 1'b0;
        end else if (update) begin
            score_player <= player_nxt;
            score_enemy  <= enemy_nxt;
            match_end    <= end_nxt;
            match_result <= result_nxt;
        end
    end

    // report FSM, a frame already requested is still sent after IDLE
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PLAY;
        end else begin
            case (state)
                PLAY: begin
                    if (update) begin
                        state <= REPORT;
                    end
                end
                REPORT: begin
                    if (link.grant) begin
                        state <= PLAY;
                    end
                end
                default: state <= PLAY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            link.data <= {end_nxt, result_nxt, player_nxt, enemy_nxt};
        end
    end

    assign link.req        = (state == REPORT);
    assign link.kind       = FRAME_SCORE;
    assign round.match_end = match_end;

    // judge stops on match_end, so the count tops out at the winning score
    a_score_cap: assert property (
        @(posedge clk) disable iff (rst)
        (score_player <= WIN_SCORE) && (score_enemy <= WIN_SCORE)
    );

endmodule

/* design/round_judge.sv */
/*
 * Round judge.
 * Captures the shot strobe and both directions, decides goal or save,
 * pulses the verdict to the score controller and queues an event frame.
 */

module round_judge import game_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  g_state game_state,
    input  logic   shot,
    input  dir_t   shot_dir,
    input  dir_t   keeper_dir,
    round_if.judge round,
    link_if.peer   link
);

    logic shot_q;
    dir_t shot_dir_q;
    dir_t keeper_dir_q;
    logic pending;      // event frame waiting for grant
    logic in_play;
    logic accept;
    logic role_now;
    logic scored_now;

    assign in_play    = (game_state == KEEPER) || (game_state == SHOOTER);
    assign accept     = shot_q && in_play && !pending && !round.match_end;
    assign role_now   = (game_state == SHOOTER);
    assign scored_now = (shot_dir_q != keeper_dir_q);   // keeper dived the wrong way

    always_ff @(posedge clk) begin
        if (rst) begin
            shot_q <= 1'b0;
        end else begin
            shot_q <= shot;
        end
    end

    // directions taken with the strobe
    always_ff @(posedge clk) begin
        shot_dir_q   <= shot_dir;
        keeper_dir_q <= keeper_dir;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            round.done <= 1'b0;
        end else begin
            round.done <= accept;
            if (accept) begin
                pending <= 1'b1;
            end else if (link.grant) begin
                pending <= 1'b0;    // req drops on this edge
            end
        end
    end

    // verdict and event byte
    always_ff @(posedge clk) begin
        if (accept) begin
            round.scored <= scored_now;
            round.role   <= role_now;
            link.data    <= {role_now, scored_now, shot_dir_q, keeper_dir_q, 2'b00};
        end
    end

    assign link.req  = pending;
    assign link.kind = FRAME_EVENT;

    // no verdict while the game sits in IDLE
    a_no_done_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        round.done |-> game_state != IDLE
    );

endmodule

/* design/round_if.sv */
/*
 * Round verdict path from the judge to the score controller,
 * with the match end level going back to the judge.
 */

interface round_if;

    logic done;         // one-cycle pulse per decided shot
    logic scored;       // valid with done
    logic role;         // 1 for shooter, valid with done
    logic match_end;

    modport judge (output done, output scored, output role, input match_end);

    modport scorer (input done, input scored, input role, output match_end);

endinterface

/* design/link_if.sv */
/*
 * Shared link port of one peer.
 * The peer holds req, kind and data until it sees grant,
 * grant is a one-cycle combinational answer from the arbiter.
 */

interface link_if import game_pkg::*; ();

    logic        req;
    frame_kind_t kind;
    frame_t      data;
    logic        grant;

    modport peer (
        output req,
        output kind,
        output data,
        input  grant
    );

    modport arbiter (
        input  req,
        input  kind,
        input  data,
        output grant
    );

endinterface

/* design/game_pkg.sv */
/*
 * Penalty shootout game definitions.
 * Game phase, shot and dive directions, score and link byte widths,
 * link frame kinds and the goal count that ends a match.
 */

package game_pkg;

    // game phase, driven by the game FSM outside this subsystem
    typedef enum logic [1:0] {
        IDLE,
        KEEPER,     // opponent shoots at the player
        SHOOTER     // player shoots
    } g_state;

    // shot or dive direction
    typedef enum logic [1:0] {
        LEFT,
        CENTER,
        RIGHT
    } dir_t;

    typedef logic [2:0] score_t;    // goals of one side
    typedef logic [7:0] frame_t;    // one byte on the partner link

    // what a link byte carries
    // score frame: match_end, match_result, player score, enemy score
    // event frame: role, scored, shot dir, keeper dir, 2'b00
    typedef enum logic {
        FRAME_EVENT,
        FRAME_SCORE
    } frame_kind_t;

    localparam score_t WIN_SCORE = 3'd5;   // first side here wins

endpackage
